// File: src/isa_pkg.sv
`default_nettype none

package isa_pkg;

   ////////////////////
   // Field widths
   ////////////////////

   localparam int INSTR_WIDTH    = 32;
   localparam int OPCODE_WIDTH   = 6;
   localparam int FUNCT_WIDTH    = 6;
   localparam int REG_ADDR_WIDTH = 5;
   localparam int SHAMT_WIDTH    = 5;

   typedef logic [OPCODE_WIDTH-1:0]   opcode_t;
   typedef logic [FUNCT_WIDTH-1:0]    funct_t;
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [SHAMT_WIDTH-1:0]    shamt_t;

   // R-type layout; I and J types overlay the low 26 bits
   typedef struct packed {
      opcode_t   opcode;                         // Bits 31..26
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t rd;
      shamt_t    shamt;
      funct_t    funct;                          // Bits 5..0
   } instr_t;

   ////////////////////
   // Opcodes
   ////////////////////

   typedef enum opcode_t {
      OP_SPECIAL = 6'd0,                         // R-type decoded by funct
      OP_J       = 6'd2,
      OP_JAL     = 6'd3,
      OP_BEQ     = 6'd4,
      OP_BNE     = 6'd5,
      OP_ADDI    = 6'd8,
      OP_SLTI    = 6'd10,
      OP_ANDI    = 6'd12,
      OP_ORI     = 6'd13,
      OP_XORI    = 6'd14,
      OP_LUI     = 6'd15,
      OP_LB      = 6'd32,
      OP_LH      = 6'd33,
      OP_LW      = 6'd35,
      OP_LBU     = 6'd36,
      OP_LHU     = 6'd37,
      OP_LWU     = 6'd39,
      OP_SB      = 6'd40,
      OP_SH      = 6'd41,
      OP_SW      = 6'd43
   } opcode_e;

   // Function codes under OP_SPECIAL
   typedef enum funct_t {
      FN_SLL  = 6'd0,
      FN_SRL  = 6'd2,
      FN_SRA  = 6'd3,
      FN_SLLV = 6'd4,
      FN_SRLV = 6'd6,
      FN_SRAV = 6'd7,
      FN_JR   = 6'd8,
      FN_JALR = 6'd9,
      FN_ADDU = 6'd33,
      FN_SUBU = 6'd35,
      FN_AND  = 6'd36,
      FN_OR   = 6'd37,
      FN_XOR  = 6'd38,
      FN_NOR  = 6'd39,
      FN_SLT  = 6'd42
   } funct_e;

endpackage

`default_nettype wire

// File: src/control_pkg.sv
`default_nettype none

package control_pkg;

   localparam int ALU_OP_WIDTH   = 2;
   localparam int ALU_CTRL_WIDTH = 4;

   ////////////////////
   // ALU operation class
   ////////////////////

   // Class 2'b11 is never produced by the main decoder
   typedef enum logic [ALU_OP_WIDTH-1:0] {
      ALU_OP_MEM   = 2'b00,                      // Address calc or LUI
      ALU_OP_JUMP  = 2'b01,                      // Branch or jump
      ALU_OP_ARITH = 2'b10
   } alu_op_e;

   ////////////////////
   // ALU control codes
   ////////////////////

   typedef enum logic [ALU_CTRL_WIDTH-1:0] {
      ALU_AND = 4'b0000,
      ALU_OR  = 4'b0001,
      ALU_ADD = 4'b0010,
      ALU_SUB = 4'b0110,
      ALU_SLT = 4'b0111,
      ALU_LUI = 4'b1000,                         // Immediate to upper half
      ALU_XOR = 4'b1001,
      ALU_NOR = 4'b1010,
      ALU_SLL = 4'b1011,
      ALU_SRL = 4'b1100,
      ALU_SRA = 4'b1101
   } alu_ctrl_e;

   // Main decoder output of 8 bits
   typedef struct packed {
      logic    reg_dst;                          // Write rd instead of rt
      logic    reg_write;
      logic    alu_src;                          // Second operand from imm/shamt
      alu_op_e alu_op;
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;
   } main_ctrl_t;

   // Decode stage register of 20 bits
   typedef struct packed {
      main_ctrl_t       ctrl;
      isa_pkg::opcode_t opcode;                  // Kept for the ALU control table
      isa_pkg::funct_t  funct;
   } decode_stage_t;

   // Top level control word of 12 bits
   typedef struct packed {
      main_ctrl_t ctrl;
      alu_ctrl_e  alu_ctrl;
   } ctrl_word_t;

endpackage

`default_nettype wire

// File: src/main_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module main_decoder
(
   input  wire logic                       i_clock,
   input  wire logic                       i_soft_reset,
   input  wire logic                       i_instr_valid,
   input  wire isa_pkg::instr_t            i_instruction,
   output logic                            o_instr_ready,
   input  wire logic                       i_ctrl_ready,
   output logic                            o_stage_valid,
   output control_pkg::decode_stage_t      o_stage
);

   control_pkg::main_ctrl_t dec_ctrl;
   logic                    accept;

   ////////////////////
   // Control table
   ////////////////////

   // Field order is reg_dst reg_write alu_src alu_op mem_read mem_write mem_to_reg
   always_comb
   begin
      dec_ctrl = '0;                                            // Unknown codes
      if (i_instruction.opcode == isa_pkg::OP_SPECIAL)
      begin
         case (i_instruction.funct)
            isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA:
            begin
               dec_ctrl = '{1'b1, 1'b1, 1'b1, control_pkg::ALU_OP_ARITH, 1'b0, 1'b0, 1'b0};
            end
            isa_pkg::FN_SLLV, isa_pkg::FN_SRLV, isa_pkg::FN_SRAV,
            isa_pkg::FN_ADDU, isa_pkg::FN_SUBU,
            isa_pkg::FN_AND, isa_pkg::FN_OR, isa_pkg::FN_XOR, isa_pkg::FN_NOR,
            isa_pkg::FN_SLT:
            begin
               dec_ctrl = '{1'b1, 1'b1, 1'b0, control_pkg::ALU_OP_ARITH, 1'b0, 1'b0, 1'b0};
            end
            isa_pkg::FN_JR:
            begin
               dec_ctrl = '{1'b0, 1'b0, 1'b0, control_pkg::ALU_OP_JUMP, 1'b0, 1'b0, 1'b0};
            end
            isa_pkg::FN_JALR:                                   // Link into rd
            begin
               dec_ctrl = '{1'b1, 1'b1, 1'b0, control_pkg::ALU_OP_JUMP, 1'b0, 1'b0, 1'b0};
            end
            default:
            begin
               dec_ctrl = '0;
            end
         endcase
      end
      else
      begin
         case (i_instruction.opcode)
            isa_pkg::OP_LB, isa_pkg::OP_LH, isa_pkg::OP_LW,
            isa_pkg::OP_LBU, isa_pkg::OP_LHU, isa_pkg::OP_LWU:
            begin
               dec_ctrl = '{1'b0, 1'b1, 1'b1, control_pkg::ALU_OP_MEM, 1'b1, 1'b0, 1'b1};
            end
            isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW:
            begin
               dec_ctrl = '{1'b0, 1'b0, 1'b1, control_pkg::ALU_OP_MEM, 1'b0, 1'b1, 1'b0};
            end
            isa_pkg::OP_ADDI, isa_pkg::OP_ANDI, isa_pkg::OP_ORI,
            isa_pkg::OP_XORI, isa_pkg::OP_SLTI:
            begin
               dec_ctrl = '{1'b0, 1'b1, 1'b1, control_pkg::ALU_OP_ARITH, 1'b0, 1'b0, 1'b0};
            end
            isa_pkg::OP_LUI:                                    // Goes through MEM class
            begin
               dec_ctrl = '{1'b0, 1'b1, 1'b1, control_pkg::ALU_OP_MEM, 1'b0, 1'b0, 1'b0};
            end
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE:
            begin
               dec_ctrl = '{1'b0, 1'b0, 1'b1, control_pkg::ALU_OP_JUMP, 1'b0, 1'b0, 1'b0};
            end
            isa_pkg::OP_J:
            begin
               dec_ctrl = '{1'b0, 1'b0, 1'b0, control_pkg::ALU_OP_JUMP, 1'b0, 1'b0, 1'b0};
            end
            isa_pkg::OP_JAL:                                    // Writes the link register
            begin
               dec_ctrl = '{1'b0, 1'b1, 1'b0, control_pkg::ALU_OP_JUMP, 1'b0, 1'b0, 1'b0};
            end
            default:
            begin
               dec_ctrl = '0;
            end
         endcase
      end
   end

   ////////////////////
   // Output register
   ////////////////////

   // Room when empty or when the consumer takes the current word
   assign o_instr_ready = ~o_stage_valid | i_ctrl_ready;
   assign accept        = i_instr_valid & o_instr_ready;

   always_ff @(posedge i_clock)
   begin
      if (!i_soft_reset)
      begin
         o_stage_valid <= 1'b0;
         o_stage       <= '0;
      end
      else
      begin
         if (accept)
         begin
            o_stage_valid <= 1'b1;
            o_stage       <= '{ctrl:   dec_ctrl,
                               opcode: i_instruction.opcode,
                               funct:  i_instruction.funct};
         end
         else if (i_ctrl_ready)
         begin
            o_stage_valid <= 1'b0;                              // Drained with nothing new
         end
      end
   end

endmodule

`default_nettype wire

// File: src/alu_control_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module alu_control_decoder
(
   input  wire control_pkg::decode_stage_t i_stage,
   output control_pkg::alu_ctrl_e          o_alu_ctrl
);

   always_comb
   begin
      case (i_stage.ctrl.alu_op)
         control_pkg::ALU_OP_MEM:
         begin
            if (i_stage.opcode == isa_pkg::OP_LUI)
            begin
               o_alu_ctrl = control_pkg::ALU_LUI;
            end
            else
            begin
               o_alu_ctrl = control_pkg::ALU_ADD;               // Base plus offset
            end
         end
         control_pkg::ALU_OP_JUMP:
         begin
            o_alu_ctrl = control_pkg::ALU_SUB;                  // Compare for branches
         end
         control_pkg::ALU_OP_ARITH:
         begin
            if (i_stage.opcode == isa_pkg::OP_SPECIAL)
            begin
               case (i_stage.funct)
                  isa_pkg::FN_SLL, isa_pkg::FN_SLLV: o_alu_ctrl = control_pkg::ALU_SLL;
                  isa_pkg::FN_SRL, isa_pkg::FN_SRLV: o_alu_ctrl = control_pkg::ALU_SRL;
                  isa_pkg::FN_SRA, isa_pkg::FN_SRAV: o_alu_ctrl = control_pkg::ALU_SRA;
                  isa_pkg::FN_ADDU:                  o_alu_ctrl = control_pkg::ALU_ADD;
                  isa_pkg::FN_SUBU:                  o_alu_ctrl = control_pkg::ALU_SUB;
                  isa_pkg::FN_AND:                   o_alu_ctrl = control_pkg::ALU_AND;
                  isa_pkg::FN_OR:                    o_alu_ctrl = control_pkg::ALU_OR;
                  isa_pkg::FN_XOR:                   o_alu_ctrl = control_pkg::ALU_XOR;
                  isa_pkg::FN_NOR:                   o_alu_ctrl = control_pkg::ALU_NOR;
                  isa_pkg::FN_SLT:                   o_alu_ctrl = control_pkg::ALU_SLT;
                  default:                           o_alu_ctrl = control_pkg::ALU_ADD;
               endcase
            end
            else
            begin
               // Immediate forms
               case (i_stage.opcode)
                  isa_pkg::OP_ADDI: o_alu_ctrl = control_pkg::ALU_ADD;
                  isa_pkg::OP_ANDI: o_alu_ctrl = control_pkg::ALU_AND;
                  isa_pkg::OP_ORI:  o_alu_ctrl = control_pkg::ALU_OR;
                  isa_pkg::OP_XORI: o_alu_ctrl = control_pkg::ALU_XOR;
                  isa_pkg::OP_SLTI: o_alu_ctrl = control_pkg::ALU_SLT;
                  default:          o_alu_ctrl = control_pkg::ALU_ADD;
               endcase
            end
         end
         default:
         begin
            o_alu_ctrl = control_pkg::ALU_SUB;                  // Unused class 11
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/mips_control_top.sv
`timescale 1ns/1ns
`default_nettype none

module mips_control_top
(
   input  wire logic                  i_clock,
   input  wire logic                  i_soft_reset,
   input  wire logic                  i_instr_valid,
   input  wire isa_pkg::instr_t       i_instruction,
   output logic                       o_instr_ready,
   input  wire logic                  i_ctrl_ready,
   output logic                       o_ctrl_valid,
   output control_pkg::ctrl_word_t    o_ctrl
);

   control_pkg::decode_stage_t stage;
   control_pkg::alu_ctrl_e     alu_ctrl;

   main_decoder u_main_decoder
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_instr_valid (i_instr_valid),
      .i_instruction (i_instruction),
      .o_instr_ready (o_instr_ready),
      .i_ctrl_ready  (i_ctrl_ready),
      .o_stage_valid (o_ctrl_valid),
      .o_stage       (stage)
   );

   // Combinational in the same cycle as the stage register
   alu_control_decoder u_alu_control_decoder
   (
      .i_stage    (stage),
      .o_alu_ctrl (alu_ctrl)
   );

   assign o_ctrl = '{ctrl: stage.ctrl, alu_ctrl: alu_ctrl};

endmodule

`default_nettype wire

// File: sim/mips_control_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mips_control_checker
(
   input wire logic                       i_clock,
   input wire logic                       i_soft_reset,
   input wire logic                       i_ctrl_ready,
   input wire logic                       i_stage_valid,
   input wire control_pkg::decode_stage_t i_stage
);

   ////////////////////
   // Handshake
   ////////////////////

   reset_clears_stage: assert property (@(posedge i_clock)
      !i_soft_reset |=> !i_stage_valid && i_stage == '0)
      else $error("Decode stage not cleared by reset");

   // Stalled word waits for the consumer
   stall_holds_stage: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      i_stage_valid && !i_ctrl_ready |=> i_stage_valid && $stable(i_stage))
      else $error("Decode stage changed while stalled");

   ////////////////////
   // Control word
   ////////////////////

   mem_access_exclusive: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      !(i_stage.ctrl.mem_read && i_stage.ctrl.mem_write))
      else $error("mem_read and mem_write both set");

   store_without_writeback: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      i_stage.ctrl.mem_write |-> !i_stage.ctrl.reg_write)
      else $error("Store also writes a register");

endmodule

`default_nettype wire

// File: sim/mips_control_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_control_tb;

   logic                    i_clock;
   logic                    i_soft_reset;
   logic                    i_instr_valid;
   isa_pkg::instr_t         i_instruction;
   logic                    i_ctrl_ready;
   logic                    o_instr_ready;
   logic                    o_ctrl_valid;
   control_pkg::ctrl_word_t o_ctrl;

   isa_pkg::instr_t stim_q[$];                                 // Not yet offered
   isa_pkg::instr_t model_q[$];                                // Accepted and not yet out
   integer          seed          = 49017;
   int              value_errors  = 0;
   int              other_errors  = 0;
   logic            next_valid    = 1'b0;
   logic            last_accepted = 1'b0;
   logic            feeding       = 1'b0;
   string           test_name     = "reset";

   mips_control_top dut0
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_instr_valid (i_instr_valid),
      .i_instruction (i_instruction),
      .o_instr_ready (o_instr_ready),
      .i_ctrl_ready  (i_ctrl_ready),
      .o_ctrl_valid  (o_ctrl_valid),
      .o_ctrl        (o_ctrl)
   );

   bind main_decoder mips_control_checker u_checker
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_ctrl_ready  (i_ctrl_ready),
      .i_stage_valid (o_stage_valid),
      .i_stage       (o_stage)
   );

   always #50 i_clock = ~i_clock;

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_main_ctrl(input string name, input control_pkg::main_ctrl_t exp,
                                  input control_pkg::main_ctrl_t act);
      if (act !== exp)
      begin
         value_errors++;
         $display("FAIL %s: control expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_alu_ctrl(input string name, input control_pkg::alu_ctrl_e exp,
                                 input control_pkg::alu_ctrl_e act);
      if (act !== exp)
      begin
         value_errors++;
         $display("FAIL %s: ALU code expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         value_errors++;
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   // Bit groups reg_dst reg_write alu_src then alu_op then mem_read mem_write mem_to_reg
   function automatic control_pkg::ctrl_word_t expected(input isa_pkg::instr_t instr);
      control_pkg::ctrl_word_t word;
      if (instr.opcode == isa_pkg::OP_SPECIAL)
      begin
         case (instr.funct)
            isa_pkg::FN_SLL:  word = {8'b111_10_000, control_pkg::ALU_SLL};
            isa_pkg::FN_SRL:  word = {8'b111_10_000, control_pkg::ALU_SRL};
            isa_pkg::FN_SRA:  word = {8'b111_10_000, control_pkg::ALU_SRA};
            isa_pkg::FN_SLLV: word = {8'b110_10_000, control_pkg::ALU_SLL};
            isa_pkg::FN_SRLV: word = {8'b110_10_000, control_pkg::ALU_SRL};
            isa_pkg::FN_SRAV: word = {8'b110_10_000, control_pkg::ALU_SRA};
            isa_pkg::FN_JR:   word = {8'b000_01_000, control_pkg::ALU_SUB};
            isa_pkg::FN_JALR: word = {8'b110_01_000, control_pkg::ALU_SUB};
            isa_pkg::FN_ADDU: word = {8'b110_10_000, control_pkg::ALU_ADD};
            isa_pkg::FN_SUBU: word = {8'b110_10_000, control_pkg::ALU_SUB};
            isa_pkg::FN_AND:  word = {8'b110_10_000, control_pkg::ALU_AND};
            isa_pkg::FN_OR:   word = {8'b110_10_000, control_pkg::ALU_OR};
            isa_pkg::FN_XOR:  word = {8'b110_10_000, control_pkg::ALU_XOR};
            isa_pkg::FN_NOR:  word = {8'b110_10_000, control_pkg::ALU_NOR};
            isa_pkg::FN_SLT:  word = {8'b110_10_000, control_pkg::ALU_SLT};
            default:          word = {8'b000_00_000, control_pkg::ALU_ADD};
         endcase
      end
      else
      begin
         case (instr.opcode)
            isa_pkg::OP_LB, isa_pkg::OP_LH, isa_pkg::OP_LW,
            isa_pkg::OP_LBU, isa_pkg::OP_LHU, isa_pkg::OP_LWU:
               word = {8'b011_00_101, control_pkg::ALU_ADD};
            isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW:
               word = {8'b001_00_010, control_pkg::ALU_ADD};
            isa_pkg::OP_ADDI: word = {8'b011_10_000, control_pkg::ALU_ADD};
            isa_pkg::OP_ANDI: word = {8'b011_10_000, control_pkg::ALU_AND};
            isa_pkg::OP_ORI:  word = {8'b011_10_000, control_pkg::ALU_OR};
            isa_pkg::OP_XORI: word = {8'b011_10_000, control_pkg::ALU_XOR};
            isa_pkg::OP_SLTI: word = {8'b011_10_000, control_pkg::ALU_SLT};
            isa_pkg::OP_LUI:  word = {8'b011_00_000, control_pkg::ALU_LUI};
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE:
               word = {8'b001_01_000, control_pkg::ALU_SUB};
            isa_pkg::OP_J:    word = {8'b000_01_000, control_pkg::ALU_SUB};
            isa_pkg::OP_JAL:  word = {8'b010_01_000, control_pkg::ALU_SUB};
            default:          word = {8'b000_00_000, control_pkg::ALU_ADD};
         endcase
      end
      return word;
   endfunction

   // About 70% listed codes and 30% fully random
   function automatic isa_pkg::instr_t random_instr();
      isa_pkg::instr_t  instr;
      isa_pkg::opcode_e op;
      isa_pkg::funct_e  fn;
      int               pick;
      instr = $random(seed);
      pick  = $unsigned($random(seed)) % 100;
      op    = op.first();
      fn    = fn.first();
      repeat (pick % op.num()) op = op.next();
      repeat (pick % fn.num()) fn = fn.next();
      if (pick < 35)
         instr.opcode = op;
      else if (pick < 70)
         instr = {isa_pkg::OP_SPECIAL, instr[25:6], fn};
      return instr;
   endfunction

   ////////////////////
   // Driver and scoreboard
   ////////////////////

   task automatic step(input bit vary_ready);
      isa_pkg::instr_t         sent;
      control_pkg::ctrl_word_t exp_word;
      logic                    accepted_now;
      @(posedge i_clock);
      if (last_accepted)
         check_flag({test_name, " latency"}, 1'b1, o_ctrl_valid);   // One cycle after accept
      if (!vary_ready && i_ctrl_ready)
         check_flag({test_name, " ready"}, 1'b1, o_instr_ready);
      if (o_ctrl_valid && i_ctrl_ready)
      begin
         if (model_q.size() == 0)
         begin
            other_errors++;
            $display("ERROR: %s gave an output with no instruction pending", test_name);
         end
         else
         begin
            sent     = model_q.pop_front();
            exp_word = expected(sent);
            check_main_ctrl(test_name, exp_word.ctrl, o_ctrl.ctrl);
            check_alu_ctrl(test_name, exp_word.alu_ctrl, o_ctrl.alu_ctrl);
         end
      end
      accepted_now = i_instr_valid & o_instr_ready;
      if (accepted_now)
         model_q.push_back(i_instruction);
      last_accepted = accepted_now;
      if (!i_instr_valid || accepted_now)                        // Hold until taken
      begin
         if (stim_q.size() > 0)
         begin
            next_valid = 1'b1;
            i_instruction <= stim_q.pop_front();
         end
         else
         begin
            next_valid = feeding && (!vary_ready || ($unsigned($random(seed)) % 5 != 0));
            i_instruction <= random_instr();
         end
      end
      i_instr_valid <= next_valid;
      i_ctrl_ready  <= vary_ready ? ($unsigned($random(seed)) % 3 != 0) : 1'b1;
   endtask

   task automatic drain(input bit vary_ready, input int limit);
      int cycles;
      cycles = 0;
      while ((stim_q.size() > 0 || next_valid || model_q.size() > 0) && cycles < limit)
      begin
         step(vary_ready);
         cycles++;
      end
      if (stim_q.size() > 0 || next_valid || model_q.size() > 0)
      begin
         other_errors++;
         $display("ERROR: %s traffic did not drain within %0d cycles", test_name, limit);
      end
   endtask

   initial
   begin
      isa_pkg::instr_t instr;
      i_clock       = 1'b0;
      i_soft_reset  = 1'b0;
      i_instr_valid = 1'b0;
      i_instruction = '0;
      i_ctrl_ready  = 1'b0;
      repeat (8) @(posedge i_clock);
      i_soft_reset <= 1'b1;
      check_flag("reset valid", 1'b0, o_ctrl_valid);
      check_flag("reset ready", 1'b1, o_instr_ready);

      // Every opcode and every function code under SPECIAL
      test_name = "sweep";
      for (int code = 0; code < 64; code++)
      begin
         instr        = $random(seed);
         instr.opcode = isa_pkg::opcode_t'(code);
         stim_q.push_back(instr);
         instr        = {isa_pkg::OP_SPECIAL, instr[25:6], isa_pkg::funct_t'(code)};
         stim_q.push_back(instr);
      end
      drain(1'b1, 2000);

      test_name = "random";
      feeding   = 1'b1;
      repeat (600) step(1'b1);
      feeding = 1'b0;
      drain(1'b0, 50);

      // Reset while a stalled word sits in the stage register
      test_name = "mid reset";
      @(posedge i_clock);
      i_instr_valid <= 1'b1;
      i_instruction <= {isa_pkg::OP_LW, 26'd0};
      i_ctrl_ready  <= 1'b0;
      repeat (2) @(posedge i_clock);
      check_flag("mid reset setup", 1'b1, o_ctrl_valid);
      i_soft_reset  <= 1'b0;
      i_instr_valid <= 1'b0;
      repeat (8) @(posedge i_clock);
      i_soft_reset <= 1'b1;
      check_flag("mid reset valid", 1'b0, o_ctrl_valid);
      check_flag("mid reset ready", 1'b1, o_instr_ready);

      test_name = "stream";                                      // Ready held high
      feeding   = 1'b1;
      repeat (60) step(1'b0);
      feeding = 1'b0;
      drain(1'b0, 20);

      $display("Errors: %0d value, %0d other", value_errors, other_errors);
      if (value_errors + other_errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: mips_control_top.f
src/isa_pkg.sv
src/control_pkg.sv
src/main_decoder.sv
src/alu_control_decoder.sv
src/mips_control_top.sv
sim/mips_control_checker.sv
sim/mips_control_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := mips_control_tb
FILELIST   := mips_control_top.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := TEST RESULT: PASS

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, whatever the binary returns
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
